/* acc_bus_arbiter.sv */
`default_nettype none

module acc_bus_arbiter
  import acc_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      fetch_req_i,
  input  bus_addr_t fetch_addr_i,
  output logic      fetch_gnt_o,
  output logic      fetch_rvalid_o,
  output word_t     fetch_rdata_o,
  input  logic      data_req_i,
  input  logic      data_we_i,
  input  bus_addr_t data_addr_i,
  input  word_t     data_wdata_i,
  output logic      data_gnt_o,
  output logic      data_rvalid_o,
  output word_t     data_rdata_o,
  output logic      bus_req_o,
  output logic      bus_we_o,
  output bus_addr_t bus_addr_o,
  output word_t     bus_wdata_o,
  input  logic      bus_gnt_i,
  input  logic      bus_rvalid_i,
  input  word_t     bus_rdata_i
);

  logic                   lock_q;
  logic                   sel_q;
  logic [OWNER_CNT_W-1:0] cnt_q;
  logic [OWNER_PTR_W-1:0] wr_ptr_q;
  logic [OWNER_PTR_W-1:0] rd_ptr_q;
  // One bit per transaction, high for the data port
  logic [OWNER_DEPTH-1:0] owner_q;

  logic sel;
  logic any_req;
  logic full;
  logic push;
  logic owner_head;

  function automatic logic [OWNER_PTR_W-1:0] ptr_inc(input logic [OWNER_PTR_W-1:0] ptr);
    if (ptr == OWNER_PTR_W'(OWNER_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Data port has priority, the choice is frozen while a request waits
  assign sel     = lock_q ? sel_q : data_req_i;
  assign any_req = sel ? data_req_i : fetch_req_i;
  assign full    = cnt_q == OWNER_CNT_W'(OWNER_DEPTH);

  assign bus_req_o   = any_req && !full;
  assign bus_we_o    = sel && data_we_i;
  assign bus_addr_o  = sel ? data_addr_i : fetch_addr_i;
  assign bus_wdata_o = sel ? data_wdata_i : '0;

  assign push        = bus_req_o && bus_gnt_i;
  assign data_gnt_o  = push && sel;
  assign fetch_gnt_o = push && !sel;

  // Responses return in grant order
  assign owner_head     = owner_q[rd_ptr_q];
  assign data_rvalid_o  = bus_rvalid_i && owner_head;
  assign fetch_rvalid_o = bus_rvalid_i && !owner_head;
  assign data_rdata_o   = bus_rdata_i;
  assign fetch_rdata_o  = bus_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q   <= 1'b0;
      sel_q    <= 1'b0;
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      lock_q <= bus_req_o && !bus_gnt_i;
      sel_q  <= sel;
      cnt_q  <= cnt_q + OWNER_CNT_W'(push) - OWNER_CNT_W'(bus_rvalid_i);
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      owner_q[wr_ptr_q] <= sel;
    end
  end

endmodule

`default_nettype wire

/* acc_core_pkg.sv */
`default_nettype none

package acc_core_pkg;

  // Fetch requests in flight, also the instruction FIFO depth
  localparam int FETCH_DEPTH = 2;
  // Outstanding bus transactions tracked by the arbiter
  localparam int OWNER_DEPTH = 4;

  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int FETCH_PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
  localparam int OWNER_CNT_W = $clog2(OWNER_DEPTH + 1);
  localparam int OWNER_PTR_W = (OWNER_DEPTH > 1) ? $clog2(OWNER_DEPTH) : 1;

  typedef logic [31:0] word_t;
  typedef logic [31:0] bus_addr_t;
  typedef logic [15:0] waddr_t;

  // Opcode sits in instr[31:28], unknown codes behave as HALT
  typedef enum logic [3:0] {
    OP_LDI  = 4'h1,
    OP_LD   = 4'h2,
    OP_ADD  = 4'h3,
    OP_ST   = 4'h4,
    OP_BNZ  = 4'h5,
    OP_HALT = 4'hF
  } opcode_e;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_RUN,
    EX_MEM_WAIT,
    EX_HALTED
  } exec_state_e;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

endpackage

`default_nettype wire

/* acc_core_tb.sv */
`default_nettype none

module acc_core_tb
  import acc_core_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NPROG        = 4;
  localparam int MAX_WORDS    = 10;
  localparam int MEM_WORDS    = 1024;
  localparam int DRAIN_CYCLES = 20;

  logic      clk_i;
  logic      arst_n_i;
  logic      fetch_enable_i;
  bus_addr_t boot_addr_i;
  logic      bus_req_o;
  logic      bus_gnt_i;
  logic      bus_we_o;
  bus_addr_t bus_addr_o;
  word_t     bus_wdata_o;
  logic      bus_rvalid_i;
  word_t     bus_rdata_i;
  logic      retire_valid_o;
  bus_addr_t retire_pc_o;
  word_t     acc_o;
  logic      core_sleep_o;

  // Program table with store addresses given as word addresses
  word_t     prog_word   [NPROG][MAX_WORDS];
  int        prog_len    [NPROG];
  bus_addr_t prog_boot   [NPROG];
  word_t     exp_acc     [NPROG];
  int        exp_st_addr [NPROG];
  word_t     exp_st_val  [NPROG];
  int        exp_retires [NPROG];
  logic      table_ready;

  word_t       mem        [MEM_WORDS];
  word_t       ref_mem    [MEM_WORDS];
  word_t       rsp_data_q [$];
  int          rsp_due_q  [$];
  bus_addr_t   wr_addr_q  [$];
  word_t       wr_data_q  [$];
  int          stall;
  int          cycle;
  int          last_due;
  logic [31:0] lcg_state;

  // ISA reference model state
  bus_addr_t m_pc;
  word_t     m_acc;
  logic      m_halted;
  int        m_retires;
  logic      req_prev;
  int        errors;
  int        total_retires;

  acc_core_wrapper i_dut (.*);

  always #20 clk_i = ~clk_i;

  function automatic word_t ins(input logic [3:0] op, input logic [15:0] operand);
    return {op, 12'd0, operand};
  endfunction

  function automatic word_t fill_word(input int idx);
    return 32'hF000_0000 | (idx * 32'h0001_0003);
  endfunction

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16]) % n;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic set_entry(input int p, input int len, input bus_addr_t boot, input word_t acc,
                           input int st_addr, input word_t st_val, input int retires);
    prog_len[p]    = len;
    prog_boot[p]   = boot;
    exp_acc[p]     = acc;
    exp_st_addr[p] = st_addr;
    exp_st_val[p]  = st_val;
    exp_retires[p] = retires;
  endtask

  task automatic build_table();
    word_t hw;
    hw = ins(OP_HALT, 16'd0);
    // Straight line with ADD wraparound and a stored word read back
    prog_word[0] = '{ins(OP_LDI, 16'h1234), ins(OP_ADD, 16'd512), ins(OP_ADD, 16'd513),
                     ins(OP_ST, 16'd514), ins(OP_LD, 16'd514), ins(OP_ADD, 16'd514),
                     hw, hw, hw, hw};
    set_entry(0, 7, 32'h100, 32'hC802_3C6E, 514, 32'hE401_1E37, 7);
    // Counter in memory runs three loop iterations with minus one at word 135
    prog_word[1] = '{ins(OP_LDI, 16'd3), ins(OP_ST, 16'd600), ins(OP_LD, 16'd600),
                     ins(OP_ADD, 16'd135), ins(OP_ST, 16'd600), ins(OP_BNZ, 16'd130),
                     hw, 32'hFFFF_FFFF, hw, hw};
    set_entry(1, 8, 32'h200, 32'h0, 600, 32'h0, 15);
    // Forward branch over a store and then a tight backward loop
    prog_word[2] = '{ins(OP_LDI, 16'd5), ins(OP_BNZ, 16'd4), ins(OP_ST, 16'd700), hw,
                     ins(OP_ADD, 16'd9), ins(OP_BNZ, 16'd4), ins(OP_LDI, 16'h00AB),
                     ins(OP_ST, 16'd701), hw, 32'hFFFF_FFFF};
    set_entry(2, 10, 32'h000, 32'h0000_00AB, 701, 32'h0000_00AB, 15);
    // Load and store traffic around a branch that is not taken
    prog_word[3] = '{ins(OP_LD, 16'd800), ins(OP_ST, 16'd801), ins(OP_LDI, 16'd0),
                     ins(OP_BNZ, 16'd256), ins(OP_LD, 16'd801), ins(OP_ADD, 16'd801),
                     ins(OP_ST, 16'd802), hw, hw, hw};
    set_entry(3, 8, 32'h400, 32'hE640_12C0, 802, 32'hE640_12C0, 8);
  endtask

  task automatic serve_request();
    int idx;
    int due;
    idx = int'(bus_addr_o[11:2]);
    if (bus_addr_o[31:12] != '0 || bus_addr_o[1:0] != 2'b00) begin
      report_mismatch($sformatf("bus access to unexpected address %h", bus_addr_o));
    end
    due = cycle + 1 + rand_below(3);
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    if (bus_we_o) begin
      mem[idx] = bus_wdata_o;
      wr_addr_q.push_back(bus_addr_o);
      wr_data_q.push_back(bus_wdata_o);
      rsp_data_q.push_back('0);
    end else begin
      rsp_data_q.push_back(mem[idx]);
    end
    rsp_due_q.push_back(due);
  endtask

  // Bus memory samples at the falling edge and drives after the rising edge
  always begin
    @(negedge clk_i);
    if (!arst_n_i) begin
      rsp_data_q.delete();
      rsp_due_q.delete();
      stall    = 0;
      last_due = 0;
    end else if (bus_req_o && bus_gnt_i) begin
      serve_request();
      stall = rand_below(3);
    end else if (bus_req_o && stall > 0) begin
      stall--;
    end
    @(posedge clk_i);
    cycle++;
    #2;
    bus_gnt_i = (stall == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      bus_rvalid_i = 1'b1;
      bus_rdata_i  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      bus_rvalid_i = 1'b0;
      bus_rdata_i  = '0;
    end
  end

  task automatic check_store(input bus_addr_t addr, input word_t data);
    if (wr_addr_q.size() == 0) begin
      report_mismatch($sformatf("ST to %h retired without a bus write", addr));
    end else begin
      if (wr_addr_q[0] !== addr || wr_data_q[0] !== data) begin
        report_mismatch($sformatf("bus write %h=%h, expected %h=%h",
                                  wr_addr_q[0], wr_data_q[0], addr, data));
      end
      void'(wr_addr_q.pop_front());
      void'(wr_data_q.pop_front());
    end
  endtask

  task automatic check_retire();
    word_t       instr;
    logic [15:0] operand;
    bus_addr_t   next_pc;
    total_retires++;
    if (m_halted) begin
      report_mismatch($sformatf("retire at pc %h after HALT", retire_pc_o));
      return;
    end
    instr   = ref_mem[m_pc[11:2]];
    operand = instr[15:0];
    next_pc = m_pc + 32'd4;
    if (retire_pc_o !== m_pc) begin
      report_mismatch($sformatf("retire pc %h, expected %h", retire_pc_o, m_pc));
    end
    case (instr[31:28])
      OP_LDI: m_acc = {16'd0, operand};
      OP_LD:  m_acc = ref_mem[operand];
      OP_ADD: m_acc = m_acc + ref_mem[operand];
      OP_ST: begin
        ref_mem[operand] = m_acc;
        check_store({14'd0, operand, 2'b00}, m_acc);
      end
      OP_BNZ: begin
        if (m_acc != '0) begin
          next_pc = {14'd0, operand, 2'b00};
        end
      end
      default: m_halted = 1'b1;
    endcase
    if (acc_o !== m_acc) begin
      report_mismatch($sformatf("acc %h at pc %h, expected %h", acc_o, m_pc, m_acc));
    end
    if (core_sleep_o !== m_halted) begin
      report_mismatch($sformatf("core_sleep_o %b at pc %h, expected %b",
                                core_sleep_o, m_pc, m_halted));
    end
    m_pc = next_pc;
    m_retires++;
  endtask

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (!fetch_enable_i && bus_req_o) begin
        report_mismatch("bus request before fetch enable");
      end
      // Only a request still waiting for its grant before HALT may finish
      if (core_sleep_o && bus_req_o && !req_prev) begin
        report_mismatch("new bus request after HALT");
      end
      if (retire_valid_o) begin
        check_retire();
      end
    end
    req_prev = arst_n_i && bus_req_o && !bus_gnt_i;
  end

  task automatic run_program(input int p);
    @(posedge clk_i);
    #2;
    arst_n_i       = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = prog_boot[p];
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < MAX_WORDS; i++) begin
      mem[prog_boot[p][11:2] + i]     = prog_word[p][i];
      ref_mem[prog_boot[p][11:2] + i] = prog_word[p][i];
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    repeat (5) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (bus_req_o !== 1'b0 || retire_valid_o !== 1'b0 || core_sleep_o !== 1'b0) begin
      report_mismatch($sformatf("program %0d outputs not idle after reset", p));
    end
    if (acc_o !== '0) begin
      report_mismatch($sformatf("acc %h after reset, expected 0", acc_o));
    end
    repeat (3) @(posedge clk_i);
    m_pc      = prog_boot[p];
    m_acc     = '0;
    m_halted  = 1'b0;
    m_retires = 0;
    #2;
    fetch_enable_i = 1'b1;
    while (!core_sleep_o) begin
      @(negedge clk_i);
    end
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    if (m_retires != exp_retires[p]) begin
      report_mismatch($sformatf("program %0d retired %0d, expected %0d",
                                p, m_retires, exp_retires[p]));
    end
    if (acc_o !== exp_acc[p]) begin
      report_mismatch($sformatf("program %0d final acc %h, expected %h", p, acc_o, exp_acc[p]));
    end
    if (mem[exp_st_addr[p]] !== exp_st_val[p]) begin
      report_mismatch($sformatf("program %0d word %0d holds %h, expected %h",
                                p, exp_st_addr[p], mem[exp_st_addr[p]], exp_st_val[p]));
    end
    if (wr_addr_q.size() != 0) begin
      report_mismatch($sformatf("program %0d made bus writes with no ST retired", p));
    end
    if (bus_req_o || rsp_due_q.size() != 0) begin
      report_mismatch($sformatf("program %0d bus not idle after HALT", p));
    end
  endtask

  initial begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    bus_gnt_i      = 1'b0;
    bus_rvalid_i   = 1'b0;
    bus_rdata_i    = '0;
    lcg_state      = 32'he48d4b76;
    stall          = 0;
    cycle          = 0;
    last_due       = 0;
    req_prev       = 1'b0;
    m_halted       = 1'b1;
    errors         = 0;
    total_retires  = 0;
    table_ready    = 1'b0;
    build_table();
    table_ready = 1'b1;
    for (int p = 0; p < NPROG; p++) begin
      run_program(p);
    end
    $display("programs=%0d retires=%0d errors=%0d", NPROG, total_retires, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the program table
  initial begin
    int limit;
    wait (table_ready === 1'b1);
    limit = 0;
    for (int p = 0; p < NPROG; p++) begin
      limit += prog_len[p] * 64 + 40;
    end
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the programs did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* acc_core_wrapper.sv */
`default_nettype none

module acc_core_wrapper
  import acc_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      fetch_enable_i,
  input  bus_addr_t boot_addr_i,
  output logic      bus_req_o,
  input  logic      bus_gnt_i,
  output logic      bus_we_o,
  output bus_addr_t bus_addr_o,
  output word_t     bus_wdata_o,
  input  logic      bus_rvalid_i,
  input  word_t     bus_rdata_i,
  // Retire trace
  output logic      retire_valid_o,
  output bus_addr_t retire_pc_o,
  output word_t     acc_o,
  output logic      core_sleep_o
);

  logic      fetch_req, fetch_gnt, fetch_rvalid;
  bus_addr_t fetch_addr;
  word_t     fetch_rdata;
  logic      data_req, data_we, data_gnt, data_rvalid;
  bus_addr_t data_addr;
  word_t     data_wdata, data_rdata;
  logic      instr_valid, instr_ready;
  word_t     instr_rdata;
  bus_addr_t instr_pc;
  logic      branch, halt;
  bus_addr_t branch_addr;
  logic      lsu_start, lsu_we, lsu_done;
  bus_addr_t lsu_addr;
  word_t     lsu_wdata, lsu_rdata;

  acc_prefetch_controller prefetch_controller_i (
    .clk_i, .arst_n_i,
    .branch_i(branch), .branch_addr_i(branch_addr), .halt_i(halt),
    .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr), .fetch_gnt_i(fetch_gnt),
    .fetch_rvalid_i(fetch_rvalid), .fetch_rdata_i(fetch_rdata),
    .instr_valid_o(instr_valid), .instr_rdata_o(instr_rdata), .instr_pc_o(instr_pc),
    .instr_ready_i(instr_ready)
  );

  acc_exec_ctrl exec_ctrl_i (
    .clk_i, .arst_n_i, .fetch_enable_i, .boot_addr_i,
    .instr_valid_i(instr_valid), .instr_rdata_i(instr_rdata), .instr_pc_i(instr_pc),
    .instr_ready_o(instr_ready), .branch_o(branch), .branch_addr_o(branch_addr),
    .halt_o(halt), .lsu_start_o(lsu_start), .lsu_we_o(lsu_we), .lsu_addr_o(lsu_addr),
    .lsu_wdata_o(lsu_wdata), .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata),
    .retire_valid_o, .retire_pc_o, .acc_o, .core_sleep_o
  );

  acc_lsu lsu_i (
    .clk_i, .arst_n_i,
    .lsu_start_i(lsu_start), .lsu_we_i(lsu_we), .lsu_addr_i(lsu_addr),
    .lsu_wdata_i(lsu_wdata), .data_req_o(data_req), .data_we_o(data_we),
    .data_addr_o(data_addr), .data_wdata_o(data_wdata), .data_gnt_i(data_gnt),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata),
    .lsu_done_o(lsu_done), .lsu_rdata_o(lsu_rdata)
  );

  acc_bus_arbiter bus_arbiter_i (
    .clk_i, .arst_n_i,
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_gnt_o(fetch_gnt),
    .fetch_rvalid_o(fetch_rvalid), .fetch_rdata_o(fetch_rdata),
    .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
    .data_wdata_i(data_wdata), .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid),
    .data_rdata_o(data_rdata),
    .bus_req_o, .bus_we_o, .bus_addr_o, .bus_wdata_o, .bus_gnt_i, .bus_rvalid_i, .bus_rdata_i
  );

endmodule

`default_nettype wire

/* acc_exec_ctrl.sv */
`default_nettype none

module acc_exec_ctrl
  import acc_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      fetch_enable_i,
  input  bus_addr_t boot_addr_i,
  input  logic      instr_valid_i,
  input  word_t     instr_rdata_i,
  input  bus_addr_t instr_pc_i,
  output logic      instr_ready_o,
  output logic      branch_o,
  output bus_addr_t branch_addr_o,
  output logic      halt_o,
  output logic      lsu_start_o,
  output logic      lsu_we_o,
  output bus_addr_t lsu_addr_o,
  output word_t     lsu_wdata_o,
  input  logic      lsu_done_i,
  input  word_t     lsu_rdata_i,
  output logic      retire_valid_o,
  output bus_addr_t retire_pc_o,
  output word_t     acc_o,
  output logic      core_sleep_o
);

  exec_state_e state_q;
  word_t       acc_q;
  logic        retire_q;
  logic        sleep_q;
  logic        lsu_start_q;
  bus_addr_t   pc_q;
  opcode_e     op_q;
  logic        lsu_we_q;
  bus_addr_t   lsu_addr_q;
  word_t       lsu_wdata_q;

  opcode_e     op;
  waddr_t      operand;
  bus_addr_t   operand_addr;
  logic        consume;
  logic        is_mem;
  logic        is_halt;
  logic        taken;

  assign op           = opcode_e'(instr_rdata_i[31:28]);
  assign operand      = instr_rdata_i[15:0];
  assign operand_addr = {14'd0, operand, 2'b00};

  // One instruction at a time, taken straight from the FIFO head
  assign consume = (state_q == EX_RUN) && instr_valid_i;
  assign is_mem  = op inside {OP_LD, OP_ADD, OP_ST};
  assign is_halt = !(op inside {OP_LDI, OP_LD, OP_ADD, OP_ST, OP_BNZ});
  assign taken   = (op == OP_BNZ) && (acc_q != '0);

  assign instr_ready_o = consume;

  // Redirect in the consume cycle so the FIFO flush lands before the next pop
  assign branch_o      = ((state_q == EX_IDLE) && fetch_enable_i) || (consume && taken);
  assign branch_addr_o = (state_q == EX_IDLE) ? boot_addr_i : operand_addr;
  assign halt_o        = consume && is_halt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= EX_IDLE;
      acc_q       <= '0;
      retire_q    <= 1'b0;
      sleep_q     <= 1'b0;
      lsu_start_q <= 1'b0;
    end else begin
      retire_q    <= 1'b0;
      lsu_start_q <= 1'b0;
      case (state_q)
        EX_IDLE: begin
          if (fetch_enable_i) begin
            state_q <= EX_RUN;
          end
        end
        EX_RUN: begin
          if (consume && is_mem) begin
            lsu_start_q <= 1'b1;
            state_q     <= EX_MEM_WAIT;
          end else if (consume) begin
            retire_q <= 1'b1;
            if (op == OP_LDI) begin
              acc_q <= {16'd0, operand};
            end else if (is_halt) begin
              sleep_q <= 1'b1;
              state_q <= EX_HALTED;
            end
          end
        end
        EX_MEM_WAIT: begin
          // Stores retire on the write response as well
          if (lsu_done_i) begin
            retire_q <= 1'b1;
            state_q  <= EX_RUN;
            if (op_q == OP_LD) begin
              acc_q <= lsu_rdata_i;
            end else if (op_q == OP_ADD) begin
              acc_q <= acc_q + lsu_rdata_i;
            end
          end
        end
        EX_HALTED: begin
          // Sleeps until reset
          state_q <= EX_HALTED;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      pc_q        <= instr_pc_i;
      op_q        <= op;
      lsu_we_q    <= (op == OP_ST);
      lsu_addr_q  <= operand_addr;
      lsu_wdata_q <= acc_q;
    end
  end

  assign lsu_start_o    = lsu_start_q;
  assign lsu_we_o       = lsu_we_q;
  assign lsu_addr_o     = lsu_addr_q;
  assign lsu_wdata_o    = lsu_wdata_q;
  assign retire_valid_o = retire_q;
  assign retire_pc_o    = pc_q;
  assign acc_o          = acc_q;
  assign core_sleep_o   = sleep_q;

endmodule

`default_nettype wire

/* acc_lsu.sv */
`default_nettype none

module acc_lsu
  import acc_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      lsu_start_i,
  input  logic      lsu_we_i,
  input  bus_addr_t lsu_addr_i,
  input  word_t     lsu_wdata_i,
  output logic      data_req_o,
  output logic      data_we_o,
  output bus_addr_t data_addr_o,
  output word_t     data_wdata_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  word_t     data_rdata_i,
  output logic      lsu_done_o,
  output word_t     lsu_rdata_o
);

  lsu_state_e state_q;
  logic       done_q;
  logic       we_q;
  bus_addr_t  addr_q;
  word_t      wdata_q;
  word_t      rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LSU_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        LSU_IDLE: begin
          if (lsu_start_i) begin
            state_q <= LSU_REQ;
          end
        end
        LSU_REQ: begin
          if (data_gnt_i) begin
            state_q <= LSU_WAIT;
          end
        end
        LSU_WAIT: begin
          if (data_rvalid_i) begin
            done_q  <= 1'b1;
            state_q <= LSU_IDLE;
          end
        end
        default: state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == LSU_IDLE) && lsu_start_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
    // Read data stays valid after the done pulse
    if ((state_q == LSU_WAIT) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = state_q == LSU_REQ;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign lsu_done_o   = done_q;
  assign lsu_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* acc_prefetch_controller.sv */
`default_nettype none

module acc_prefetch_controller
  import acc_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      branch_i,
  input  bus_addr_t branch_addr_i,
  input  logic      halt_i,
  output logic      fetch_req_o,
  output bus_addr_t fetch_addr_o,
  input  logic      fetch_gnt_i,
  input  logic      fetch_rvalid_i,
  input  word_t     fetch_rdata_i,
  output logic      instr_valid_o,
  output word_t     instr_rdata_o,
  output bus_addr_t instr_pc_o,
  input  logic      instr_ready_i
);

  logic                   active_q;
  logic                   pend_q;
  logic                   stale_q;
  bus_addr_t              addr_q;
  bus_addr_t              target_q;
  bus_addr_t              rsp_pc_q;
  logic [FETCH_CNT_W-1:0] inflight_q;
  logic [FETCH_CNT_W-1:0] drop_q;
  logic [FETCH_CNT_W-1:0] fifo_cnt_q;
  logic [FETCH_PTR_W-1:0] wr_ptr_q;
  logic [FETCH_PTR_W-1:0] rd_ptr_q;
  word_t                  fifo_data_q [FETCH_DEPTH];
  bus_addr_t              fifo_pc_q   [FETCH_DEPTH];

  logic [FETCH_CNT_W:0]   used;
  logic [FETCH_CNT_W-1:0] drop_base;
  logic                   room;
  logic                   grant;
  logic                   grant_stale;
  logic                   rsp_drop;
  logic                   rsp_keep;
  logic                   pop;

  function automatic logic [FETCH_PTR_W-1:0] ptr_inc(input logic [FETCH_PTR_W-1:0] ptr);
    if (ptr == FETCH_PTR_W'(FETCH_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Queued words plus outstanding requests bound the fetch window
  assign used = fifo_cnt_q + inflight_q;
  assign room = used < FETCH_DEPTH;

  // A raised request stays up until granted, even across a branch or halt
  assign fetch_req_o  = pend_q | (active_q & room & ~halt_i);
  assign fetch_addr_o = addr_q;

  assign grant       = fetch_req_o & fetch_gnt_i;
  assign grant_stale = grant & (branch_i | stale_q);
  assign rsp_drop    = fetch_rvalid_i & (branch_i | (drop_q != '0));
  assign rsp_keep    = fetch_rvalid_i & ~rsp_drop;
  assign pop         = instr_valid_o & instr_ready_i;

  // Everything in flight at a branch belongs to the old stream
  assign drop_base = branch_i ? inflight_q : drop_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q   <= 1'b0;
      pend_q     <= 1'b0;
      stale_q    <= 1'b0;
      inflight_q <= '0;
      drop_q     <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      if (branch_i) begin
        active_q <= 1'b1;
      end else if (halt_i) begin
        active_q <= 1'b0;
      end
      pend_q     <= fetch_req_o & ~fetch_gnt_i;
      stale_q    <= fetch_req_o & ~fetch_gnt_i & (branch_i | stale_q);
      inflight_q <= inflight_q + FETCH_CNT_W'(grant) - FETCH_CNT_W'(fetch_rvalid_i);
      drop_q     <= drop_base - FETCH_CNT_W'(rsp_drop) + FETCH_CNT_W'(grant_stale);
      if (branch_i) begin
        fifo_cnt_q <= '0;
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
      end else begin
        fifo_cnt_q <= fifo_cnt_q + FETCH_CNT_W'(rsp_keep) - FETCH_CNT_W'(pop);
        if (rsp_keep) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      target_q <= branch_addr_i;
    end
    // A held request keeps its address, the target is taken after its grant
    if (grant) begin
      if (branch_i) begin
        addr_q <= branch_addr_i;
      end else if (stale_q) begin
        addr_q <= target_q;
      end else begin
        addr_q <= addr_q + 32'd4;
      end
    end else if (branch_i && !fetch_req_o) begin
      addr_q <= branch_addr_i;
    end
    // Kept responses arrive in order starting at the branch target
    if (branch_i) begin
      rsp_pc_q <= branch_addr_i;
    end else if (rsp_keep) begin
      rsp_pc_q <= rsp_pc_q + 32'd4;
    end
    if (rsp_keep) begin
      fifo_data_q[wr_ptr_q] <= fetch_rdata_i;
      fifo_pc_q[wr_ptr_q]   <= rsp_pc_q;
    end
  end

  assign instr_valid_o = fifo_cnt_q != '0;
  assign instr_rdata_o = fifo_data_q[rd_ptr_q];
  assign instr_pc_o    = fifo_pc_q[rd_ptr_q];

endmodule

`default_nettype wire

/* acc_prefetch_controller_properties.sv */
`default_nettype none

module acc_prefetch_controller_properties
  import acc_core_pkg::*;
(
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   branch_i,
  input logic                   fetch_req_o,
  input bus_addr_t              fetch_addr_o,
  input logic                   fetch_gnt_i,
  input logic                   instr_valid_o,
  input logic [FETCH_CNT_W-1:0] fifo_cnt_q,
  input logic [FETCH_CNT_W-1:0] inflight_q
);
  timeunit 1ns;
  timeprecision 1ps;

  // A waiting fetch keeps its request and address until the grant
  req_held_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fetch_req_o && !fetch_gnt_i |=> fetch_req_o && $stable(fetch_addr_o))
    else $error("fetch request dropped or changed before its grant");

  // Queued words and outstanding fetches share one window
  fetch_window_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fifo_cnt_q + inflight_q) <= FETCH_DEPTH)
    else $error("instruction FIFO plus fetches in flight exceed the fetch depth");

  // The flush empties the FIFO at once
  flush_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    branch_i |=> !instr_valid_o)
    else $error("instruction valid in the cycle after a branch");

endmodule

bind acc_prefetch_controller acc_prefetch_controller_properties i_prefetch_props (.*);

`default_nettype wire

/* files.f */
acc_core_pkg.sv
acc_prefetch_controller.sv
acc_exec_ctrl.sv
acc_lsu.sv
acc_bus_arbiter.sv
acc_core_wrapper.sv
acc_prefetch_controller_properties.sv
acc_core_tb.sv
